//--- vlog.f
logic/miss_arb_pkg.sv
logic/mem_read_if.sv
logic/mem_rdata_if.sv
logic/icache_miss_adapter.sv
logic/read_req_arbiter.sv
logic/read_resp_router.sv
logic/icache_refill_packer.sv
logic/miss_read_arbiter_top.sv
testbench/miss_read_chk.sv
testbench/tb_miss_read_arbiter.sv

//--- testbench/tb_miss_read_arbiter.sv
// Testbench for the read-side miss arbiter: memory model with credits,
// directed tests, typed compare tasks and the summary
`timescale 1ns/1ps

module tb_miss_read_arbiter;
   import miss_arb_pkg::*;

   localparam int unsigned CREDITS    = 4;
   localparam mem_id_t     ICACHE_ID  = 4'd15;
   localparam mem_id_t     UC_READ_ID = 4'd14;
   localparam int          TMO        = 300;

   logic clk_i = 1'b0;
   logic rst_ni;
   logic icache_miss_valid_i, icache_miss_ready_o, icache_miss_nc_i, icache_resp_valid_o;
   mem_addr_t icache_miss_addr_i, dcache_miss_addr_i, uc_read_addr_i, mem_req_addr_o;
   icache_line_t icache_resp_data_o;
   logic dcache_miss_valid_i, dcache_miss_ready_o, dcache_miss_resp_valid_o;
   logic dcache_miss_resp_ready_i, dcache_miss_resp_last_o;
   mem_id_t dcache_miss_id_i, dcache_miss_resp_id_o, mem_req_id_o, mem_resp_id_i;
   mem_data_t dcache_miss_resp_data_o, uc_read_resp_data_o, mem_resp_data_i;
   logic uc_read_valid_i, uc_read_ready_o, uc_read_resp_valid_o, uc_read_resp_ready_i;
   logic uc_read_resp_last_o;
   logic mem_req_valid_o, mem_req_cacheable_o, mem_req_credit_i;
   logic mem_resp_valid_i, mem_resp_ready_o, mem_resp_last_i;
   mem_len_t mem_req_len_o;

   // Issue log, pending model work and delivered results
   logic iss_cache[$];
   mem_len_t iss_len[$];
   mem_id_t iss_id[$];
   mem_addr_t m_addr[$];
   mem_len_t m_len[$];
   mem_id_t m_id[$];
   icache_line_t lines[$];
   mem_data_t dc_data[$];
   mem_id_t dc_id[$];
   logic dc_last[$];
   mem_data_t uc_data[$];
   logic uc_last[$];

   logic [31:0] lfsr = 32'h1f6f;
   int owed = 0;
   int credit_allow = 0;
   logic credit_hold = 1'b0;
   int errors = 0;
   int checks = 0;
   int tests = 0;

   miss_read_arbiter_top #(
      .CREDITS (CREDITS), .ICACHE_ID (ICACHE_ID), .UC_READ_ID (UC_READ_ID)
   ) u_dut (.*);

   always #10 clk_i = ~clk_i;

   // Galois LFSR, one step per bit taken
   function automatic int rand_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
         v = (v << 1) | lfsr[0];
      end
      return v;
   endfunction

   function automatic mem_data_t beat_of(input mem_addr_t a, input int k, input mem_id_t id);
      return {id, 28'h0, a + 32'(k)};
   endfunction

   task automatic report(input string msg);
      errors++;
      $display("CHECK FAILED @%0t: %s", $time, msg);
   endtask

   task automatic check_line(input icache_line_t got, input icache_line_t exp, input string m);
      checks++;
      if (got !== exp) report($sformatf("%s got %h exp %h", m, got, exp));
   endtask

   task automatic check_data(input mem_data_t got, input mem_data_t exp, input string m);
      checks++;
      if (got !== exp) report($sformatf("%s got %h exp %h", m, got, exp));
   endtask

   task automatic check_id(input mem_id_t got, input mem_id_t exp, input string m);
      checks++;
      if (got !== exp) report($sformatf("%s got %0d exp %0d", m, got, exp));
   endtask

   task automatic check_len(input mem_len_t got, input mem_len_t exp, input string m);
      checks++;
      if (got !== exp) report($sformatf("%s got %0d exp %0d", m, got, exp));
   endtask

   task automatic check_flag(input logic got, input logic exp, input string m);
      checks++;
      if (got !== exp) report($sformatf("%s got %b exp %b", m, got, exp));
   endtask

   // Observation on the rising edge
   always @(posedge clk_i) begin
      if (rst_ni) begin
         if (mem_req_valid_o) begin
            iss_cache.push_back(mem_req_cacheable_o);
            iss_len.push_back(mem_req_len_o);
            iss_id.push_back(mem_req_id_o);
            m_addr.push_back(mem_req_addr_o);
            m_len.push_back(mem_req_len_o);
            m_id.push_back(mem_req_id_o);
            owed++;
         end
         if (icache_resp_valid_o) lines.push_back(icache_resp_data_o);
         if (dcache_miss_resp_valid_o && dcache_miss_resp_ready_i) begin
            dc_data.push_back(dcache_miss_resp_data_o);
            dc_id.push_back(dcache_miss_resp_id_o);
            dc_last.push_back(dcache_miss_resp_last_o);
         end
         if (uc_read_resp_valid_o && uc_read_resp_ready_i) begin
            uc_data.push_back(uc_read_resp_data_o);
            uc_last.push_back(uc_read_resp_last_o);
         end
      end
   end

   // Memory response beats
   initial begin : memory_model
      mem_addr_t a;
      mem_len_t len;
      mem_id_t id;
      int waited;
      logic accepted;
      forever begin
         @(negedge clk_i);
         if (m_id.size() != 0) begin
            a = m_addr.pop_front();
            len = m_len.pop_front();
            id = m_id.pop_front();
            repeat (rand_bits(2)) @(negedge clk_i);
            for (int k = 0; k <= int'(len); k++) begin
               mem_resp_valid_i = 1'b1;
               mem_resp_id_i = id;
               mem_resp_data_i = beat_of(a, k, id);
               mem_resp_last_i = (k == int'(len));
               waited = 0;
               accepted = 1'b0;
               while (!accepted && waited < TMO) begin
                  @(posedge clk_i);
                  if (mem_resp_ready_o) accepted = 1'b1;
                  else waited++;
               end
               if (!accepted) begin
                  errors++;
                  $display("memory response beat was never accepted");
               end
               @(negedge clk_i);
               mem_resp_valid_i = 1'b0;
            end
         end
      end
   end

   // Credit return after a short random gap
   initial begin : credit_model
      forever begin
         @(negedge clk_i);
         mem_req_credit_i = 1'b0;
         if (owed > 0 && (!credit_hold || credit_allow > 0)) begin
            repeat (rand_bits(2)) @(negedge clk_i);
            mem_req_credit_i = 1'b1;
            owed--;
            if (credit_hold) credit_allow--;
         end
      end
   end

   function automatic int count_of(input int sel);
      case (sel)
         0: return lines.size();
         1: return dc_data.size();
         2: return uc_data.size();
         default: return iss_id.size();
      endcase
   endfunction

   task automatic wait_count(input int sel, input int target, input string what);
      int n;
      n = 0;
      while (count_of(sel) < target && n < TMO) begin
         @(negedge clk_i);
         n++;
      end
      if (count_of(sel) < target) begin
         errors++;
         $display("timeout waiting for %s", what);
      end
   endtask

   function automatic logic resp_valid(input int sel);
      return (sel == 1) ? dcache_miss_resp_valid_o : uc_read_resp_valid_o;
   endfunction

   // Consumer ready held low, memory side must stall
   task automatic expect_stall(input int sel, input string what);
      int n;
      n = 0;
      while (!resp_valid(sel) && n < TMO) begin
         @(posedge clk_i);
         n++;
      end
      if (!resp_valid(sel)) begin
         errors++;
         $display("timeout waiting for a %s response beat", what);
      end
      repeat (3) begin
         @(posedge clk_i);
         if (mem_resp_ready_o) report($sformatf("memory response not stalled by %s", what));
      end
      @(negedge clk_i);
   endtask

   // Raise the chosen valids at a falling edge, drop each after its handshake
   task automatic handshake(input logic [2:0] which);
      logic [2:0] pend;
      int n;
      pend = which;
      n = 0;
      icache_miss_valid_i = pend[0];
      dcache_miss_valid_i = pend[1];
      uc_read_valid_i = pend[2];
      while (pend != 3'b000 && n < TMO) begin
         @(posedge clk_i);
         if (icache_miss_valid_i && icache_miss_ready_o) pend[0] = 1'b0;
         if (dcache_miss_valid_i && dcache_miss_ready_o) pend[1] = 1'b0;
         if (uc_read_valid_i && uc_read_ready_o) pend[2] = 1'b0;
         @(negedge clk_i);
         icache_miss_valid_i = pend[0];
         dcache_miss_valid_i = pend[1];
         uc_read_valid_i = pend[2];
         n++;
      end
      if (pend != 3'b000) begin
         errors++;
         $display("timeout waiting for a request handshake");
      end
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while ((m_id.size() != 0 || owed != 0 || mem_resp_valid_i) && n < TMO) begin
         @(negedge clk_i);
         n++;
      end
      if (n >= TMO) begin
         errors++;
         $display("timeout waiting for the memory model to drain");
      end
      repeat (3) @(negedge clk_i);
   endtask

   task automatic apply_reset();
      rst_ni = 1'b0;
      repeat (10) @(negedge clk_i);
      rst_ni = 1'b1;
      @(negedge clk_i);
   endtask

   task automatic end_test(input string name, input int err0);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == err0) ? "ok" : "FAILED");
   endtask

   task automatic test_icache_line();
      int e0 = errors;
      int b = iss_id.size();
      icache_miss_addr_i = 32'h1000;
      icache_miss_nc_i = 1'b0;
      handshake(3'b001);
      wait_count(0, 1, "icache line");
      check_len(iss_len[b], mem_len_t'(LINE_BEATS - 1), "icache line length");
      check_id(iss_id[b], ICACHE_ID, "icache line id");
      check_flag(iss_cache[b], 1'b1, "icache line cacheable");
      check_line(lines[0], {beat_of(32'h1000, 1, ICACHE_ID), beat_of(32'h1000, 0, ICACHE_ID)},
                 "icache line data");
      end_test("cacheable icache miss", e0);
   endtask

   task automatic test_icache_uncached();
      int e0 = errors;
      int b = iss_id.size();
      int n = 0;
      icache_miss_addr_i = 32'h2000;
      icache_miss_nc_i = 1'b1;
      handshake(3'b001);
      // Entry stays busy until the refill has been handed over
      while (lines.size() < 2 && n < TMO) begin
         @(posedge clk_i);
         if (icache_miss_ready_o && lines.size() < 2) report("miss ready before refill");
         n++;
      end
      wait_count(0, 2, "uncached icache line");
      check_len(iss_len[b], '0, "uncached icache length");
      check_flag(iss_cache[b], 1'b0, "uncached icache cacheable");
      check_line(lines[1], {64'h0, beat_of(32'h2000, 0, ICACHE_ID)}, "uncached icache line");
      @(negedge clk_i);
      end_test("uncached icache miss", e0);
   endtask

   task automatic test_dcache_and_uc();
      int e0 = errors;
      int b = iss_id.size();
      dcache_miss_addr_i = 32'h3000;
      dcache_miss_id_i = 4'd3;
      dcache_miss_resp_ready_i = 1'b0;
      handshake(3'b010);
      expect_stall(1, "dcache ready");
      dcache_miss_resp_ready_i = 1'b1;
      wait_count(1, 2, "dcache response beats");
      for (int k = 0; k < 2; k++) begin
         check_data(dc_data[k], beat_of(32'h3000, k, 4'd3), "dcache data");
         check_id(dc_id[k], 4'd3, "dcache id");
         check_flag(dc_last[k], (k == LINE_BEATS - 1), "dcache last");
      end
      check_len(iss_len[b], mem_len_t'(LINE_BEATS - 1), "dcache length");
      check_flag(iss_cache[b], 1'b1, "dcache cacheable");
      uc_read_addr_i = 32'h4000;
      uc_read_resp_ready_i = 1'b0;
      handshake(3'b100);
      expect_stall(2, "uncached read ready");
      uc_read_resp_ready_i = 1'b1;
      wait_count(2, 1, "uncached read response");
      check_data(uc_data[0], beat_of(32'h4000, 0, UC_READ_ID), "uncached read data");
      check_flag(uc_last[0], 1'b1, "uncached read last");
      check_id(iss_id[b + 1], UC_READ_ID, "uncached read id");
      check_len(iss_len[b + 1], '0, "uncached read length");
      check_flag(iss_cache[b + 1], 1'b0, "uncached read cacheable");
      end_test("dcache and uncached responses", e0);
   endtask

   task automatic test_rr_order();
      int e0 = errors;
      int b;
      wait_idle();
      apply_reset();
      b = iss_id.size();
      icache_miss_addr_i = 32'h5000;
      icache_miss_nc_i = 1'b0;
      dcache_miss_addr_i = 32'h6000;
      dcache_miss_id_i = 4'd5;
      uc_read_addr_i = 32'h7000;
      // Adapter registers the miss, its request reaches the arbiter a cycle later
      handshake(3'b001);
      handshake(3'b110);
      wait_count(3, b + 3, "three issued requests");
      check_id(iss_id[b], ICACHE_ID, "first grant");
      check_id(iss_id[b + 1], 4'd5, "second grant");
      check_id(iss_id[b + 2], UC_READ_ID, "third grant");
      wait_count(0, 3, "icache line after order test");
      wait_idle();
      end_test("round-robin order after reset", e0);
   endtask

   task automatic test_credits();
      int e0 = errors;
      int b = iss_id.size();
      credit_hold = 1'b1;
      credit_allow = 0;
      dcache_miss_addr_i = 32'h8000;
      dcache_miss_id_i = 4'd2;
      dcache_miss_valid_i = 1'b1;
      for (int c = 0; c < 50; c++) begin
         @(posedge clk_i);
         if (dcache_miss_ready_o) begin
            @(negedge clk_i);
            dcache_miss_addr_i = dcache_miss_addr_i + 32'h40;
         end else begin
            @(negedge clk_i);
         end
         if (c == 30) credit_allow = 1;
         if (c == 29) begin
            checks++;
            if (iss_id.size() - b != CREDITS) report("issues with credits withheld");
         end
      end
      checks++;
      if (iss_id.size() - b != CREDITS + 1) report("issues after one credit returned");
      dcache_miss_valid_i = 1'b0;
      credit_hold = 1'b0;
      wait_idle();
      end_test("credit limit", e0);
   endtask

   initial begin : watchdog
      #2_000_000;
      $display("simulation ran past its time limit");
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      rst_ni = 1'b0;
      icache_miss_valid_i = 1'b0;
      icache_miss_addr_i = '0;
      icache_miss_nc_i = 1'b0;
      dcache_miss_valid_i = 1'b0;
      dcache_miss_addr_i = '0;
      dcache_miss_id_i = '0;
      dcache_miss_resp_ready_i = 1'b1;
      uc_read_valid_i = 1'b0;
      uc_read_addr_i = '0;
      uc_read_resp_ready_i = 1'b1;
      mem_req_credit_i = 1'b0;
      mem_resp_valid_i = 1'b0;
      mem_resp_id_i = '0;
      mem_resp_data_i = '0;
      mem_resp_last_i = 1'b0;
      @(negedge clk_i);
      apply_reset();
      test_icache_line();
      test_icache_uncached();
      test_dcache_and_uc();
      test_rr_order();
      test_credits();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule : tb_miss_read_arbiter

//--- testbench/miss_read_chk.sv
// Credit and issue assertions for the read request arbiter, bound in below
`timescale 1ns/1ps

module miss_read_chk #(
   parameter int unsigned CREDITS = 4
) (
   input logic       clk_i,
   input logic       rst_ni,
   input logic [7:0] credit_i,
   input logic       valid_i,
   input logic       grant_i
);

   // Counter can never grow past its reset value
   a_credit_max : assert property (@(posedge clk_i) disable iff (!rst_ni)
      credit_i <= CREDITS)
      else $error("credit count above the reset value");

   // Issue cycle still counts its own credit
   a_no_issue_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
      valid_i |-> credit_i != 0)
      else $error("request issued with no credit");

   // Every issue cycle needs a requester handshake in the cycle before
   a_one_cycle_issue : assert property (@(posedge clk_i) disable iff (!rst_ni)
      valid_i |-> $past(grant_i))
      else $error("request valid without a grant in the previous cycle");

endmodule : miss_read_chk

bind read_req_arbiter miss_read_chk #(.CREDITS(CREDITS)) u_chk (
   .clk_i    (clk_i),
   .rst_ni   (rst_ni),
   .credit_i (8'(credit_q)),
   .valid_i  (mem_req_valid_o),
   .grant_i  ((icache.valid & icache.ready) |
              (dcache_miss_valid_i & dcache_miss_ready_o) |
              (uc_read_valid_i & uc_read_ready_o))
);

//--- logic/miss_read_arbiter_top.sv
// Read-side miss arbiter top level: icache adapter, request arbiter,
// response router and refill packer
`timescale 1ns/1ps

module miss_read_arbiter_top import miss_arb_pkg::*; #(
   parameter int unsigned CREDITS    = 4,
   parameter mem_id_t     ICACHE_ID  = 4'd15,
   parameter mem_id_t     UC_READ_ID = 4'd14
) (
   input  logic         clk_i,
   input  logic         rst_ni,

   // Instruction cache
   input  logic         icache_miss_valid_i,
   output logic         icache_miss_ready_o,
   input  mem_addr_t    icache_miss_addr_i,
   input  logic         icache_miss_nc_i,
   output logic         icache_resp_valid_o,
   output icache_line_t icache_resp_data_o,

   // Data cache miss port
   input  logic         dcache_miss_valid_i,
   output logic         dcache_miss_ready_o,
   input  mem_addr_t    dcache_miss_addr_i,
   input  mem_id_t      dcache_miss_id_i,
   output logic         dcache_miss_resp_valid_o,
   input  logic         dcache_miss_resp_ready_i,
   output mem_data_t    dcache_miss_resp_data_o,
   output mem_id_t      dcache_miss_resp_id_o,
   output logic         dcache_miss_resp_last_o,

   // Data cache uncached reads
   input  logic         uc_read_valid_i,
   output logic         uc_read_ready_o,
   input  mem_addr_t    uc_read_addr_i,
   output logic         uc_read_resp_valid_o,
   input  logic         uc_read_resp_ready_i,
   output mem_data_t    uc_read_resp_data_o,
   output logic         uc_read_resp_last_o,

   // Memory read channel
   output logic         mem_req_valid_o,
   output mem_addr_t    mem_req_addr_o,
   output mem_len_t     mem_req_len_o,
   output mem_id_t      mem_req_id_o,
   output logic         mem_req_cacheable_o,
   input  logic         mem_req_credit_i,
   input  logic         mem_resp_valid_i,
   output logic         mem_resp_ready_o,
   input  mem_id_t      mem_resp_id_i,
   input  mem_data_t    mem_resp_data_i,
   input  logic         mem_resp_last_i
);

   logic refill_done;

   mem_read_if  ic_req_if ();
   mem_rdata_if refill_if ();

   icache_miss_adapter #(
      .ICACHE_ID (ICACHE_ID)
   ) u_icache_miss_adapter (
      .clk_i               (clk_i),
      .rst_ni              (rst_ni),
      .icache_miss_valid_i (icache_miss_valid_i),
      .icache_miss_ready_o (icache_miss_ready_o),
      .icache_miss_addr_i  (icache_miss_addr_i),
      .icache_miss_nc_i    (icache_miss_nc_i),
      .refill_done_i       (refill_done),
      .req                 (ic_req_if.requester)
   );

   read_req_arbiter #(
      .CREDITS    (CREDITS),
      .UC_READ_ID (UC_READ_ID)
   ) u_read_req_arbiter (
      .clk_i               (clk_i),
      .rst_ni              (rst_ni),
      .icache              (ic_req_if.arbiter),
      .dcache_miss_valid_i (dcache_miss_valid_i),
      .dcache_miss_ready_o (dcache_miss_ready_o),
      .dcache_miss_addr_i  (dcache_miss_addr_i),
      .dcache_miss_id_i    (dcache_miss_id_i),
      .uc_read_valid_i     (uc_read_valid_i),
      .uc_read_ready_o     (uc_read_ready_o),
      .uc_read_addr_i      (uc_read_addr_i),
      .mem_req_valid_o     (mem_req_valid_o),
      .mem_req_addr_o      (mem_req_addr_o),
      .mem_req_len_o       (mem_req_len_o),
      .mem_req_id_o        (mem_req_id_o),
      .mem_req_cacheable_o (mem_req_cacheable_o),
      .mem_req_credit_i    (mem_req_credit_i)
   );

   read_resp_router #(
      .ICACHE_ID  (ICACHE_ID),
      .UC_READ_ID (UC_READ_ID)
   ) u_read_resp_router (
      .mem_resp_valid_i         (mem_resp_valid_i),
      .mem_resp_ready_o         (mem_resp_ready_o),
      .mem_resp_id_i            (mem_resp_id_i),
      .mem_resp_data_i          (mem_resp_data_i),
      .mem_resp_last_i          (mem_resp_last_i),
      .dcache_miss_resp_valid_o (dcache_miss_resp_valid_o),
      .dcache_miss_resp_ready_i (dcache_miss_resp_ready_i),
      .dcache_miss_resp_data_o  (dcache_miss_resp_data_o),
      .dcache_miss_resp_id_o    (dcache_miss_resp_id_o),
      .dcache_miss_resp_last_o  (dcache_miss_resp_last_o),
      .uc_read_resp_valid_o     (uc_read_resp_valid_o),
      .uc_read_resp_ready_i     (uc_read_resp_ready_i),
      .uc_read_resp_data_o      (uc_read_resp_data_o),
      .uc_read_resp_last_o      (uc_read_resp_last_o),
      .refill                   (refill_if.source)
   );

   icache_refill_packer u_icache_refill_packer (
      .clk_i               (clk_i),
      .rst_ni              (rst_ni),
      .refill              (refill_if.sink),
      .icache_resp_valid_o (icache_resp_valid_o),
      .icache_resp_data_o  (icache_resp_data_o),
      .refill_done_o       (refill_done)
   );

endmodule : miss_read_arbiter_top

//--- logic/icache_refill_packer.sv
// Instruction-cache refill packer, assembles response beats into one line
`timescale 1ns/1ps

module icache_refill_packer import miss_arb_pkg::*; (
   input  logic         clk_i,
   input  logic         rst_ni,

   mem_rdata_if.sink    refill,

   output logic         icache_resp_valid_o,
   output icache_line_t icache_resp_data_o,
   output logic         refill_done_o
);

   localparam int unsigned BEAT_W = $bits(mem_data_t);

   refill_state_e state_q;
   icache_line_t  line_q;
   logic          resp_valid_q;

   // Never stalls the memory
   assign refill.ready = 1'b1;

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state_q      <= REFILL_IDLE;
         resp_valid_q <= 1'b0;
      end else begin
         resp_valid_q <= refill.valid & refill.last;
         if (refill.valid) begin
            if (state_q == REFILL_IDLE && !refill.last) begin
               state_q <= REFILL_HIGH;
            end else begin
               state_q <= REFILL_IDLE;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (refill.valid) begin
         if (state_q == REFILL_IDLE) begin
            line_q[BEAT_W-1:0] <= refill.data;
            // Single beat refill, upper half reads as zero
            if (refill.last) begin
               line_q[2*BEAT_W-1:BEAT_W] <= '0;
            end
         end else begin
            line_q[2*BEAT_W-1:BEAT_W] <= refill.data;
         end
      end
   end

   assign icache_resp_valid_o = resp_valid_q;
   assign icache_resp_data_o  = line_q;
   assign refill_done_o       = resp_valid_q;

endmodule : icache_refill_packer

//--- logic/read_resp_router.sv
// Memory read response router, steers each beat to its consumer by ID
`timescale 1ns/1ps

module read_resp_router import miss_arb_pkg::*; #(
   parameter mem_id_t ICACHE_ID  = 4'd15,
   parameter mem_id_t UC_READ_ID = 4'd14
) (
   input  logic      mem_resp_valid_i,
   output logic      mem_resp_ready_o,
   input  mem_id_t   mem_resp_id_i,
   input  mem_data_t mem_resp_data_i,
   input  logic      mem_resp_last_i,

   output logic      dcache_miss_resp_valid_o,
   input  logic      dcache_miss_resp_ready_i,
   output mem_data_t dcache_miss_resp_data_o,
   output mem_id_t   dcache_miss_resp_id_o,
   output logic      dcache_miss_resp_last_o,

   output logic      uc_read_resp_valid_o,
   input  logic      uc_read_resp_ready_i,
   output mem_data_t uc_read_resp_data_o,
   output logic      uc_read_resp_last_o,

   mem_rdata_if.source refill
);

   logic to_icache;
   logic to_uc;
   logic to_dcache;

   // Icache ID wins, any ID not reserved belongs to the dcache
   assign to_icache = (mem_resp_id_i == ICACHE_ID);
   assign to_uc     = ~to_icache & (mem_resp_id_i == UC_READ_ID);
   assign to_dcache = ~to_icache & ~to_uc;

   assign refill.valid = mem_resp_valid_i & to_icache;
   assign refill.id    = mem_resp_id_i;
   assign refill.data  = mem_resp_data_i;
   assign refill.last  = mem_resp_last_i;

   assign dcache_miss_resp_valid_o = mem_resp_valid_i & to_dcache;
   assign dcache_miss_resp_data_o  = mem_resp_data_i;
   assign dcache_miss_resp_id_o    = mem_resp_id_i;
   assign dcache_miss_resp_last_o  = mem_resp_last_i;

   assign uc_read_resp_valid_o = mem_resp_valid_i & to_uc;
   assign uc_read_resp_data_o  = mem_resp_data_i;
   assign uc_read_resp_last_o  = mem_resp_last_i;

   assign mem_resp_ready_o = to_icache ? refill.ready :
                             to_uc     ? uc_read_resp_ready_i : dcache_miss_resp_ready_i;

endmodule : read_resp_router

//--- logic/read_req_arbiter.sv
// Round-robin read request arbiter for three requesters, with the memory
// request credit counter and the registered issue stage
`timescale 1ns/1ps

module read_req_arbiter import miss_arb_pkg::*; #(
   parameter int unsigned CREDITS    = 4,
   parameter mem_id_t     UC_READ_ID = 4'd14
) (
   input  logic      clk_i,
   input  logic      rst_ni,

   mem_read_if.arbiter icache,

   input  logic      dcache_miss_valid_i,
   output logic      dcache_miss_ready_o,
   input  mem_addr_t dcache_miss_addr_i,
   input  mem_id_t   dcache_miss_id_i,

   input  logic      uc_read_valid_i,
   output logic      uc_read_ready_o,
   input  mem_addr_t uc_read_addr_i,

   output logic      mem_req_valid_o,
   output mem_addr_t mem_req_addr_o,
   output mem_len_t  mem_req_len_o,
   output mem_id_t   mem_req_id_o,
   output logic      mem_req_cacheable_o,
   input  logic      mem_req_credit_i
);

   localparam int unsigned CNT_W = $clog2(CREDITS + 1);

   logic [CNT_W-1:0] credit_q;
   logic [1:0]       last_q;
   logic [1:0]       win_idx;
   logic             win_any;
   logic [2:0]       req_vec;
   logic             can_issue;
   logic             fire;
   logic             req_valid_q;

   // Index 0 icache, 1 dcache miss, 2 uncached read
   assign req_vec = {uc_read_valid_i, dcache_miss_valid_i, icache.valid};

   // First valid requester after the last granted one
   always_comb begin
      int unsigned idx;
      win_idx = last_q;
      win_any = 1'b0;
      for (int unsigned k = 1; k <= 3; k++) begin
         idx = (int'(last_q) + k) % 3;
         if (!win_any && req_vec[idx]) begin
            win_any = 1'b1;
            win_idx = 2'(idx);
         end
      end
   end

   // The request sitting on the issue stage still holds a credit
   assign can_issue = credit_q > CNT_W'(req_valid_q);
   assign fire      = win_any & can_issue;

   assign icache.ready        = fire & (win_idx == 2'd0);
   assign dcache_miss_ready_o = fire & (win_idx == 2'd1);
   assign uc_read_ready_o     = fire & (win_idx == 2'd2);

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         req_valid_q <= 1'b0;
         last_q      <= 2'd2;
      end else begin
         req_valid_q <= fire;
         if (fire) begin
            last_q <= win_idx;
         end
      end
   end

   // Issue stage payload
   always_ff @(posedge clk_i) begin
      if (fire) begin
         case (win_idx)
            2'd0: begin
               mem_req_addr_o      <= icache.addr;
               mem_req_len_o       <= icache.len;
               mem_req_id_o        <= icache.id;
               mem_req_cacheable_o <= icache.cacheable;
            end
            2'd1: begin
               mem_req_addr_o      <= dcache_miss_addr_i;
               mem_req_len_o       <= mem_len_t'(LINE_BEATS - 1);
               mem_req_id_o        <= dcache_miss_id_i;
               mem_req_cacheable_o <= 1'b1;
            end
            default: begin
               mem_req_addr_o      <= uc_read_addr_i;
               mem_req_len_o       <= '0;
               mem_req_id_o        <= UC_READ_ID;
               mem_req_cacheable_o <= 1'b0;
            end
         endcase
      end
   end

   // Credits: one spent per issue, one back per return pulse
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         credit_q <= CNT_W'(CREDITS);
      end else begin
         case ({mem_req_credit_i, req_valid_q})
            2'b10:   credit_q <= credit_q + 1'b1;
            2'b01:   credit_q <= credit_q - 1'b1;
            default: credit_q <= credit_q;
         endcase
      end
   end

   assign mem_req_valid_o = req_valid_q;

endmodule : read_req_arbiter

//--- logic/icache_miss_adapter.sv
// Instruction-cache miss adapter: holds one miss, offers it once as a read request
`timescale 1ns/1ps

module icache_miss_adapter import miss_arb_pkg::*; #(
   parameter mem_id_t ICACHE_ID = 4'd15
) (
   input  logic      clk_i,
   input  logic      rst_ni,

   input  logic      icache_miss_valid_i,
   output logic      icache_miss_ready_o,
   input  mem_addr_t icache_miss_addr_i,
   input  logic      icache_miss_nc_i,

   input  logic      refill_done_i,

   mem_read_if.requester req
);

   logic      held_q;
   logic      pending_q;
   mem_addr_t addr_q;
   logic      nc_q;

   logic      miss_accept;
   logic      req_granted;

   assign icache_miss_ready_o = ~held_q;
   assign miss_accept         = icache_miss_valid_i & ~held_q;
   assign req_granted         = req.valid & req.ready;

   // Entry state, one miss at a time
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         held_q    <= 1'b0;
         pending_q <= 1'b0;
      end else if (refill_done_i) begin
         held_q    <= 1'b0;
         pending_q <= 1'b0;
      end else if (miss_accept) begin
         held_q    <= 1'b1;
         pending_q <= 1'b0;
      end else if (req_granted) begin
         pending_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (miss_accept) begin
         addr_q <= icache_miss_addr_i;
         nc_q   <= icache_miss_nc_i;
      end
   end

   // Uncached miss reads a single word, cacheable miss a full line
   assign req.valid     = held_q & ~pending_q;
   assign req.addr      = addr_q;
   assign req.len       = nc_q ? mem_len_t'(0) : mem_len_t'(LINE_BEATS - 1);
   assign req.id        = ICACHE_ID;
   assign req.cacheable = ~nc_q;

endmodule : icache_miss_adapter

//--- logic/mem_rdata_if.sv
// Read response beat channel from the response router to the refill packer
`timescale 1ns/1ps

interface mem_rdata_if import miss_arb_pkg::*; ();

   logic      valid;
   logic      ready;
   mem_id_t   id;
   mem_data_t data;
   logic      last;

   modport source (
      output valid, id, data, last,
      input  ready
   );

   modport sink (
      input  valid, id, data, last,
      output ready
   );

endinterface : mem_rdata_if

//--- logic/mem_read_if.sv
// Read request channel between one requester and the request arbiter
`timescale 1ns/1ps

interface mem_read_if import miss_arb_pkg::*; ();

   logic      valid;
   logic      ready;
   mem_addr_t addr;
   mem_len_t  len;
   mem_id_t   id;
   logic      cacheable;

   // Payload held stable while valid is high
   modport requester (
      output valid, addr, len, id, cacheable,
      input  ready
   );

   modport arbiter (
      input  valid, addr, len, id, cacheable,
      output ready
   );

endinterface : mem_read_if

//--- logic/miss_arb_pkg.sv
// Shared widths, instruction-cache line geometry and the refill FSM
// state encoding for the read-side miss arbiter
package miss_arb_pkg;

   // Physical byte address
   typedef logic [31:0] mem_addr_t;

   // One beat on the memory read data bus
   typedef logic [63:0] mem_data_t;

   // Full instruction-cache line as handed back to the cache
   typedef logic [127:0] icache_line_t;

   // Transaction ID, used to route responses
   typedef logic [3:0] mem_id_t;

   // Burst length, beat count minus one
   typedef logic [1:0] mem_len_t;

   // Beats needed to fill one instruction-cache line
   localparam int unsigned LINE_BEATS = $bits(icache_line_t) / $bits(mem_data_t);

   // Refill packer states
   typedef enum logic {
      REFILL_IDLE,
      REFILL_HIGH
   } refill_state_e;

endpackage : miss_arb_pkg
